/* hw/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// PC held in reset, first request goes one word past it
`define CORE_RESET_PC 32'h7FFF_FFFC

// Register file geometry
`define CORE_NUM_REGS 32
`define CORE_RADDR_W  5

// Data path width, also the value field on the commit port
`define CORE_XLEN 32

`endif

/* hw/isa_pkg.sv */
package isa_pkg;

    ////////////////////////////////////////////////////////////
    // Opcode and function fields
    ////////////////////////////////////////////////////////////

    // Major opcodes in inst[6:0]
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;

    // funct3 of the supported register ops
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct7, SUB is the only alternate encoding
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    ////////////////////////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////////////////////////

    // R layout, I type reads funct7 and rs2 as imm[11:0]
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_rtype_s;

    // U layout, JAL keeps its immediate scrambled in imm20
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_utype_s;

    typedef union packed {
        rv_rtype_s r;
        rv_utype_s u;
    } rv_inst_u;

    // Operation carried from decode to execute
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B,
        ALU_LINK
    } alu_op_e;

endpackage

/* hw/pipe_pkg.sv */
`include "core_config.svh"

package pipe_pkg;

    // Fetch to decode
    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [31:0]           inst;
    } fd_s;

    // Decode to execute, operands already selected
    typedef struct packed {
        logic [`CORE_XLEN-1:0]    pc;
        isa_pkg::alu_op_e         alu_op;
        logic [`CORE_XLEN-1:0]    a;
        logic [`CORE_XLEN-1:0]    b;
        logic [`CORE_RADDR_W-1:0] rd;
        logic                     writes;
    } de_s;

    // Execute to result
    typedef struct packed {
        logic [`CORE_XLEN-1:0]    pc;
        logic [`CORE_RADDR_W-1:0] rd;
        logic [`CORE_XLEN-1:0]    value;
        logic                     writes;
    } er_s;

    // Retire report
    typedef struct packed {
        logic [`CORE_XLEN-1:0]    pc;
        logic [`CORE_RADDR_W-1:0] rd;
        logic [`CORE_XLEN-1:0]    value;
    } commit_s;

endpackage

/* hw/fetch_stage.sv */
`include "core_config.svh"

module fetch_stage (
    input  logic          I_sys_clk,
    input  logic          I_rst,
    // Instruction memory
    output logic          pc_valid,
    output logic [31:0]   pc,
    input  logic          inst_ready,
    input  logic          inst_valid,
    input  logic [31:0]   inst,
    // To decode
    output logic          fd_valid,
    output pipe_pkg::fd_s fd,
    input  logic          fd_allow_in,
    // Jump from decode
    input  logic          redirect_valid,
    input  logic [31:0]   redirect_pc
);

    logic        fetch_en;
    logic        if_valid;     // request accepted, item not yet handed on
    logic        cache_valid;
    logic [31:0] inst_cache;
    logic [31:0] inst_pc;      // address of the item in flight
    logic        drop_q;       // next response is on the wrong path
    logic        tgt_pend;
    logic [31:0] tgt_pc;
    logic        resp_live;
    logic        if_ready_go;
    logic        if_allow_in;
    logic        req_fire;

    ////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////

    assign resp_live   = inst_valid && !drop_q;
    assign if_ready_go = resp_live || cache_valid;
    assign if_allow_in = !if_valid || (if_ready_go && fd_allow_in);
    assign pc_valid    = if_allow_in && fetch_en;
    assign req_fire    = pc_valid && inst_ready;

    // Response passes straight through unless buffered
    assign fd_valid = if_valid && if_ready_go;
    assign fd.pc    = inst_pc;
    assign fd.inst  = cache_valid ? inst_cache : inst;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst)
            fetch_en <= 1'b0;
        else
            fetch_en <= 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Request address
    ////////////////////////////////////////////////////////////

    // Step off the reset PC as fetch comes up
    always_ff @(posedge I_sys_clk) begin
        if (I_rst)
            pc <= `CORE_RESET_PC;
        else if (!fetch_en)
            pc <= pc + 32'd4;
        else if (req_fire) begin
            if (redirect_valid)
                pc <= redirect_pc;
            else if (tgt_pend)
                pc <= tgt_pc;
            else
                pc <= pc + 32'd4;
        end else if (redirect_valid && !pc_valid)
            pc <= redirect_pc;
    end

    // Shown request must stay put, so park the target until it is taken
    always_ff @(posedge I_sys_clk) begin
        if (I_rst)
            tgt_pend <= 1'b0;
        else if (redirect_valid && pc_valid && !inst_ready)
            tgt_pend <= 1'b1;
        else if (req_fire)
            tgt_pend <= 1'b0;
    end

    always_ff @(posedge I_sys_clk) begin
        if (redirect_valid)
            tgt_pc <= redirect_pc;
        if (req_fire)
            inst_pc <= pc;
        // Hold what decode refused
        if (inst_valid && !fd_allow_in)
            inst_cache <= inst;
    end

    ////////////////////////////////////////////////////////////
    // Item tracking
    ////////////////////////////////////////////////////////////

    always_ff @(posedge I_sys_clk) begin
        if (I_rst)
            drop_q <= 1'b0;
        else if (redirect_valid && ((if_valid && !if_ready_go) || pc_valid))
            drop_q <= 1'b1;
        else if (inst_valid)
            drop_q <= 1'b0;
    end

    always_ff @(posedge I_sys_clk) begin
        if (I_rst)
            cache_valid <= 1'b0;
        else if (redirect_valid)
            cache_valid <= 1'b0;
        else if (resp_live && !fd_allow_in)
            cache_valid <= 1'b1;
        else if (fd_allow_in)
            cache_valid <= 1'b0;
    end

    always_ff @(posedge I_sys_clk) begin
        if (I_rst)
            if_valid <= 1'b0;
        else if (req_fire)
            if_valid <= 1'b1;
        else if (redirect_valid && if_ready_go)
            if_valid <= 1'b0;
        else if (inst_valid && drop_q)
            if_valid <= 1'b0;
        else if (fd_valid && fd_allow_in)
            if_valid <= 1'b0;
    end

endmodule

/* hw/decode_stage.sv */
`include "core_config.svh"

module decode_stage (
    input  logic                     I_sys_clk,
    input  logic                     I_rst,
    // From fetch
    input  logic                     fd_valid,
    input  pipe_pkg::fd_s            fd,
    output logic                     fd_allow_in,
    // To execute
    output logic                     de_valid,
    output pipe_pkg::de_s            de,
    input  logic                     de_allow_in,
    // Pending writers downstream
    input  logic                     ex_busy,
    input  logic [`CORE_RADDR_W-1:0] ex_busy_rd,
    input  logic                     rs_busy,
    input  logic [`CORE_RADDR_W-1:0] rs_busy_rd,
    // Register file read port
    output logic [`CORE_RADDR_W-1:0] rf_raddr1,
    output logic [`CORE_RADDR_W-1:0] rf_raddr2,
    input  logic [`CORE_XLEN-1:0]    rf_rdata1,
    input  logic [`CORE_XLEN-1:0]    rf_rdata2,
    // Jump to fetch
    output logic                     redirect_valid,
    output logic [31:0]              redirect_pc
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic        d_valid;
    fd_s         d_item;
    rv_inst_u    word;
    alu_op_e     alu_op;
    logic        supported;
    logic        use_rs1;
    logic        use_rs2;
    logic        is_jal;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        stall;
    logic        d_allow_in;

    // Nonzero source still owned by a downstream writer
    function automatic logic rd_hit(input logic [4:0] rs, input logic busy,
                                    input logic [4:0] busy_rd);
        return busy && (busy_rd == rs) && (rs != 5'd0);
    endfunction

    ////////////////////////////////////////////////////////////
    // Field decode
    ////////////////////////////////////////////////////////////

    assign word  = d_item.inst;
    assign imm_i = {{20{word.r.funct7[6]}}, word.r.funct7, word.r.rs2};
    assign imm_u = {word.u.imm20, 12'b0};
    // Unscramble imm[20|10:1|11|19:12]
    assign imm_j = {{11{word.u.imm20[19]}}, word.u.imm20[19], word.u.imm20[7:0],
                    word.u.imm20[8], word.u.imm20[18:9], 1'b0};

    always_comb begin
        alu_op    = ALU_ADD;
        supported = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        is_jal    = 1'b0;
        case (word.r.opcode)
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (word.r.funct3)
                    F3_ADD: begin
                        if (word.r.funct7 == F7_SUB)
                            alu_op = ALU_SUB;
                        supported = (word.r.funct7 == F7_BASE) || (word.r.funct7 == F7_SUB);
                    end
                    F3_XOR: begin
                        alu_op    = ALU_XOR;
                        supported = (word.r.funct7 == F7_BASE);
                    end
                    F3_OR: begin
                        alu_op    = ALU_OR;
                        supported = (word.r.funct7 == F7_BASE);
                    end
                    F3_AND: begin
                        alu_op    = ALU_AND;
                        supported = (word.r.funct7 == F7_BASE);
                    end
                    default: supported = 1'b0;
                endcase
            end
            OPC_OPIMM: begin
                use_rs1   = 1'b1;
                supported = (word.r.funct3 == F3_ADD);
            end
            OPC_LUI: begin
                alu_op    = ALU_PASS_B;
                supported = 1'b1;
            end
            OPC_JAL: begin
                alu_op    = ALU_LINK;
                supported = 1'b1;
                is_jal    = 1'b1;
            end
            default: supported = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Operands and hand-off
    ////////////////////////////////////////////////////////////

    assign rf_raddr1 = word.r.rs1;
    assign rf_raddr2 = word.r.rs2;

    always_comb begin
        de.pc     = d_item.pc;
        de.alu_op = alu_op;
        de.a      = rf_rdata1;
        de.b      = rf_rdata2;
        de.rd     = word.r.rd;
        de.writes = supported;
        case (word.r.opcode)
            OPC_OPIMM: de.b = imm_i;
            OPC_LUI:   de.b = imm_u;
            OPC_JAL:   de.a = d_item.pc + 32'd4;
            default:   ;
        endcase
        // Unknown ops retire a zero value
        if (!supported) begin
            de.a = '0;
            de.b = '0;
        end
    end

    assign stall = (use_rs1 && (rd_hit(word.r.rs1, ex_busy, ex_busy_rd) ||
                                rd_hit(word.r.rs1, rs_busy, rs_busy_rd))) ||
                   (use_rs2 && (rd_hit(word.r.rs2, ex_busy, ex_busy_rd) ||
                                rd_hit(word.r.rs2, rs_busy, rs_busy_rd)));

    assign de_valid   = d_valid && !stall;
    assign d_allow_in = !d_valid || (!stall && de_allow_in);

    // Jump fires as JAL leaves, the word behind it is refused
    assign redirect_valid = de_valid && de_allow_in && is_jal;
    assign redirect_pc    = d_item.pc + imm_j;
    assign fd_allow_in    = d_allow_in && !redirect_valid;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst)
            d_valid <= 1'b0;
        else if (d_allow_in)
            d_valid <= fd_valid && fd_allow_in;
    end

    always_ff @(posedge I_sys_clk) begin
        if (fd_valid && fd_allow_in)
            d_item <= fd;
    end

endmodule

/* hw/execute_stage.sv */
`include "core_config.svh"

module execute_stage (
    input  logic                     I_sys_clk,
    input  logic                     I_rst,
    // From decode
    input  logic                     de_valid,
    input  pipe_pkg::de_s            de,
    output logic                     de_allow_in,
    // To result
    output logic                     er_valid,
    output pipe_pkg::er_s            er,
    input  logic                     er_allow_in,
    // Writer held here, for the decode stall
    output logic                     ex_busy,
    output logic [`CORE_RADDR_W-1:0] ex_busy_rd
);
    import isa_pkg::*;

    logic [`CORE_XLEN-1:0] alu_res;

    always_comb begin
        case (de.alu_op)
            ALU_ADD:    alu_res = de.a + de.b;
            ALU_SUB:    alu_res = de.a - de.b;
            ALU_AND:    alu_res = de.a & de.b;
            ALU_OR:     alu_res = de.a | de.b;
            ALU_XOR:    alu_res = de.a ^ de.b;
            ALU_PASS_B: alu_res = de.b;
            ALU_LINK:   alu_res = de.a;  // Return address built in decode
            default:    alu_res = '0;
        endcase
    end

    // Single cycle, moves on whenever result takes it
    assign de_allow_in = !er_valid || er_allow_in;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst)
            er_valid <= 1'b0;
        else if (de_allow_in)
            er_valid <= de_valid;
    end

    always_ff @(posedge I_sys_clk) begin
        if (de_valid && de_allow_in) begin
            er.pc     <= de.pc;
            er.rd     <= de.rd;
            er.value  <= alu_res;
            er.writes <= de.writes;
        end
    end

    assign ex_busy    = er_valid && er.writes;
    assign ex_busy_rd = er.rd;

endmodule

/* hw/result_stage.sv */
`include "core_config.svh"

module result_stage (
    input  logic                     I_sys_clk,
    input  logic                     I_rst,
    // From execute
    input  logic                     er_valid,
    input  pipe_pkg::er_s            er,
    output logic                     er_allow_in,
    // Register file read port for decode
    input  logic [`CORE_RADDR_W-1:0] rf_raddr1,
    input  logic [`CORE_RADDR_W-1:0] rf_raddr2,
    output logic [`CORE_XLEN-1:0]    rf_rdata1,
    output logic [`CORE_XLEN-1:0]    rf_rdata2,
    // Write not yet visible on the read port
    output logic                     rs_busy,
    output logic [`CORE_RADDR_W-1:0] rs_busy_rd,
    // Retire
    output logic                     commit_valid,
    output pipe_pkg::commit_s        commit
);
    import pipe_pkg::*;

    er_s                   r_item;
    logic [`CORE_XLEN-1:0] rf [`CORE_NUM_REGS];
    logic                  rf_we;

    assign er_allow_in = 1'b1;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst)
            commit_valid <= 1'b0;
        else
            commit_valid <= er_valid && er_allow_in;
    end

    always_ff @(posedge I_sys_clk) begin
        if (er_valid && er_allow_in)
            r_item <= er;
    end

    // x0 writes dropped here, the commit still reports them
    assign rf_we = commit_valid && r_item.writes && (r_item.rd != '0);

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++)
                rf[i] <= '0;
        end else if (rf_we)
            rf[r_item.rd] <= r_item.value;
    end

    assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : rf[rf_raddr1];
    assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : rf[rf_raddr2];

    assign rs_busy    = commit_valid && r_item.writes;
    assign rs_busy_rd = r_item.rd;

    assign commit.pc    = r_item.pc;
    assign commit.rd    = r_item.rd;
    assign commit.value = r_item.value;

endmodule

/* hw/core_top.sv */
`include "core_config.svh"

module core_top (
    input  logic              I_sys_clk,
    input  logic              I_rst,
    // Instruction memory
    output logic              pc_valid,
    output logic [31:0]       pc,
    input  logic              inst_ready,
    input  logic              inst_valid,
    input  logic [31:0]       inst,
    // Retire report
    output logic              commit_valid,
    output pipe_pkg::commit_s commit
);
    import pipe_pkg::*;

    // Stage boundaries
    logic fd_valid;
    logic fd_allow_in;
    fd_s  fd;
    logic de_valid;
    logic de_allow_in;
    de_s  de;
    logic er_valid;
    logic er_allow_in;
    er_s  er;

    // Redirect, hazard and register file side paths
    logic                     redirect_valid;
    logic [31:0]              redirect_pc;
    logic                     ex_busy;
    logic [`CORE_RADDR_W-1:0] ex_busy_rd;
    logic                     rs_busy;
    logic [`CORE_RADDR_W-1:0] rs_busy_rd;
    logic [`CORE_RADDR_W-1:0] rf_raddr1;
    logic [`CORE_RADDR_W-1:0] rf_raddr2;
    logic [`CORE_XLEN-1:0]    rf_rdata1;
    logic [`CORE_XLEN-1:0]    rf_rdata2;

    fetch_stage u_fetch (
        .I_sys_clk      (I_sys_clk),
        .I_rst          (I_rst),
        .pc_valid       (pc_valid),
        .pc             (pc),
        .inst_ready     (inst_ready),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .fd_valid       (fd_valid),
        .fd             (fd),
        .fd_allow_in    (fd_allow_in),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    decode_stage u_decode (
        .I_sys_clk      (I_sys_clk),
        .I_rst          (I_rst),
        .fd_valid       (fd_valid),
        .fd             (fd),
        .fd_allow_in    (fd_allow_in),
        .de_valid       (de_valid),
        .de             (de),
        .de_allow_in    (de_allow_in),
        .ex_busy        (ex_busy),
        .ex_busy_rd     (ex_busy_rd),
        .rs_busy        (rs_busy),
        .rs_busy_rd     (rs_busy_rd),
        .rf_raddr1      (rf_raddr1),
        .rf_raddr2      (rf_raddr2),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    execute_stage u_execute (
        .I_sys_clk   (I_sys_clk),
        .I_rst       (I_rst),
        .de_valid    (de_valid),
        .de          (de),
        .de_allow_in (de_allow_in),
        .er_valid    (er_valid),
        .er          (er),
        .er_allow_in (er_allow_in),
        .ex_busy     (ex_busy),
        .ex_busy_rd  (ex_busy_rd)
    );

    result_stage u_result (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .er_valid     (er_valid),
        .er           (er),
        .er_allow_in  (er_allow_in),
        .rf_raddr1    (rf_raddr1),
        .rf_raddr2    (rf_raddr2),
        .rf_rdata1    (rf_rdata1),
        .rf_rdata2    (rf_rdata2),
        .rs_busy      (rs_busy),
        .rs_busy_rd   (rs_busy_rd),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic I_sys_clk,
    output logic I_rst
);

    initial begin
        I_sys_clk = 1'b0;
        forever #(PERIOD / 2) I_sys_clk = ~I_sys_clk;
    end

    // Reset held over the first rising edges
    initial begin
        I_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge I_sys_clk);
        I_rst <= 1'b0;
    end

endmodule

/* test/core_chk.sv */
module core_chk (
    input logic              I_sys_clk,
    input logic              I_rst,
    input logic              pc_valid,
    input logic [31:0]       pc,
    input logic              inst_ready,
    input logic              commit_valid,
    input pipe_pkg::commit_s commit
);

    // Failures seen so far, read by the testbench top
    int fail_count = 0;

    // Request address held until memory takes it
    pc_held: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        pc_valid && !inst_ready |=> $stable(pc))
        else begin
            fail_count++;
            $error("pc changed while a fetch request was still waiting");
        end

    pc_aligned: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        pc_valid |-> pc[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("fetch request address is not word aligned");
        end

    commit_aligned: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        commit_valid |-> commit.pc[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("commit pc is not word aligned");
        end

    // Nothing leaves the core right after a reset edge
    quiet_after_reset: assert property (@(posedge I_sys_clk)
        I_rst |=> !pc_valid && !commit_valid)
        else begin
            fail_count++;
            $error("request or commit raised right after reset");
        end

endmodule

bind core_top core_chk u_chk (
    .I_sys_clk    (I_sys_clk),
    .I_rst        (I_rst),
    .pc_valid     (pc_valid),
    .pc           (pc),
    .inst_ready   (inst_ready),
    .commit_valid (commit_valid),
    .commit       (commit)
);

/* test/tb_commit_monitor.sv */
`include "core_config.svh"

module tb_commit_monitor (
    input  logic              I_sys_clk,
    input  logic              I_rst,
    input  logic              pc_valid,
    input  logic [31:0]       pc,
    input  logic              commit_valid,
    input  pipe_pkg::commit_s commit,
    input  logic [63:0][31:0] mem,
    output int                error_count,
    output int                commit_count
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    logic        rst_q;
    logic        first_req_seen;

    initial begin
        error_count    = 0;
        commit_count   = 0;
        rst_q          = 1'b0;
        first_req_seen = 1'b0;
    end

    ////////////////////////////////////////////////////////////
    // ISA reference
    ////////////////////////////////////////////////////////////

    // One instruction at at_pc, x0 reads zero from the never written slot
    function automatic commit_s expected_commit(input logic [31:0] at_pc,
                                                input logic [31:0] w,
                                                output logic [31:0] pc_next,
                                                output logic wr);
        rv_inst_u    inst_v;
        logic [31:0] rs1_v;
        logic [31:0] rs2_v;
        logic [31:0] imm_i;
        logic [31:0] imm_j;
        commit_s     res;
        inst_v    = w;
        rs1_v     = ref_regs[inst_v.r.rs1];
        rs2_v     = ref_regs[inst_v.r.rs2];
        imm_i     = {{20{w[31]}}, w[31:20]};
        imm_j     = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        res.pc    = at_pc;
        res.rd    = inst_v.r.rd;
        res.value = '0;
        pc_next   = at_pc + 32'd4;
        wr        = 1'b0;
        case (inst_v.r.opcode)
            OPC_OP: begin
                wr = 1'b1;
                case ({inst_v.r.funct7, inst_v.r.funct3})
                    {F7_BASE, F3_ADD}: res.value = rs1_v + rs2_v;
                    {F7_SUB, F3_ADD}:  res.value = rs1_v - rs2_v;
                    {F7_BASE, F3_AND}: res.value = rs1_v & rs2_v;
                    {F7_BASE, F3_OR}:  res.value = rs1_v | rs2_v;
                    {F7_BASE, F3_XOR}: res.value = rs1_v ^ rs2_v;
                    default:           wr = 1'b0;
                endcase
            end
            OPC_OPIMM: begin
                if (inst_v.r.funct3 == F3_ADD) begin
                    wr        = 1'b1;
                    res.value = rs1_v + imm_i;
                end
            end
            OPC_LUI: begin
                wr        = 1'b1;
                res.value = {inst_v.u.imm20, 12'h000};
            end
            OPC_JAL: begin
                wr        = 1'b1;
                res.value = at_pc + 32'd4;
                pc_next   = at_pc + imm_j;
            end
            // Unknown op, zero value and no write
            default: ;
        endcase
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////////////////////////

    always @(posedge I_sys_clk) begin : compare
        commit_s     exp;
        logic [31:0] pc_next;
        logic        wr;
        // Outputs quiet through reset and the first cycle after it
        if (rst_q) begin
            if (pc_valid !== 1'b0) begin
                error_count++;
                $display("%0t: pc_valid was not low during reset or the cycle after", $time);
            end
            if (commit_valid !== 1'b0) begin
                error_count++;
                $display("%0t: commit_valid was not low during reset or the cycle after",
                         $time);
            end
        end
        rst_q = I_rst;
        if (I_rst) begin
            ref_pc         = `CORE_RESET_PC + 32'd4;
            first_req_seen = 1'b0;
            for (int i = 0; i < 32; i++)
                ref_regs[i] = '0;
        end else begin
            if (pc_valid === 1'b1 && !first_req_seen) begin
                first_req_seen = 1'b1;
                if (pc !== `CORE_RESET_PC + 32'd4) begin
                    error_count++;
                    $display("Mismatch at %0t: first pc got %h expected %h",
                             $time, pc, `CORE_RESET_PC + 32'd4);
                end
            end
            if (commit_valid === 1'b1) begin
                exp = expected_commit(ref_pc, mem[ref_pc[7:2]], pc_next, wr);
                if (commit.pc !== exp.pc) begin
                    error_count++;
                    $display("Mismatch at %0t: commit.pc got %h expected %h",
                             $time, commit.pc, exp.pc);
                end
                if (commit.rd !== exp.rd) begin
                    error_count++;
                    $display("Mismatch at %0t: commit.rd got %0d expected %0d",
                             $time, commit.rd, exp.rd);
                end
                if (commit.value !== exp.value) begin
                    error_count++;
                    $display("Mismatch at %0t: commit.value got %h expected %h",
                             $time, commit.value, exp.value);
                end
                // x0 stays zero
                if (wr && exp.rd != 5'd0)
                    ref_regs[exp.rd] = exp.value;
                ref_pc = pc_next;
                commit_count++;
            end
        end
    end

endmodule

/* test/tb_core.sv */
module tb_core;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int NUM_WORDS         = 64;
    localparam int NUM_COMMITS       = 200;
    localparam int CYCLES_PER_COMMIT = 12;
    localparam int RESET_CYCLES      = 5;
    localparam int WATCHDOG_CYCLES   = NUM_COMMITS * CYCLES_PER_COMMIT + RESET_CYCLES;

    logic                       I_sys_clk;
    logic                       I_rst;
    logic                       pc_valid;
    logic [31:0]                pc;
    logic                       inst_ready = 1'b0;
    logic                       inst_valid = 1'b0;
    logic [31:0]                inst       = '0;
    logic                       commit_valid;
    commit_s                    commit;
    logic [NUM_WORDS-1:0][31:0] mem;
    logic [31:0]                rng_state  = 32'd81605;
    int                         error_count;
    int                         commit_count;
    // Memory model state
    logic                       mem_busy   = 1'b0;
    int                         wait_cnt   = 0;
    logic [31:0]                req_addr   = '0;

    tb_clock_gen #(
        .PERIOD       (40),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst)
    );

    core_top u_dut (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .pc_valid     (pc_valid),
        .pc           (pc),
        .inst_ready   (inst_ready),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    tb_commit_monitor u_monitor (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .pc_valid     (pc_valid),
        .pc           (pc),
        .commit_valid (commit_valid),
        .commit       (commit),
        .mem          (mem),
        .error_count  (error_count),
        .commit_count (commit_count)
    );

    ////////////////////////////////////////////////////////////
    // Random program
    ////////////////////////////////////////////////////////////

    // LCG step, upper bits returned
    function automatic int next_rand(input int n);
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return int'(rng_state[31:8]) % n;
    endfunction

    // Mostly x0 to x3 so results feed each other
    function automatic logic [4:0] pick_reg();
        if (next_rand(8) == 0)
            return 5'(next_rand(32));
        return 5'(next_rand(4));
    endfunction

    function automatic logic [31:0] random_instr();
        rv_inst_u    w;
        logic [20:0] off;
        int          kind;
        int          sel;
        kind       = next_rand(16);
        w.r.rd     = pick_reg();
        w.r.rs1    = pick_reg();
        w.r.rs2    = pick_reg();
        w.r.funct3 = F3_ADD;
        w.r.funct7 = F7_BASE;
        w.r.opcode = OPC_OP;
        if (kind < 8) begin
            sel = next_rand(5);
            case (sel)
                1:       w.r.funct7 = F7_SUB;
                2:       w.r.funct3 = F3_AND;
                3:       w.r.funct3 = F3_OR;
                4:       w.r.funct3 = F3_XOR;
                default: ;
            endcase
        end else if (kind < 11) begin
            // ADDI, imm sits over funct7 and rs2
            w.r.opcode            = OPC_OPIMM;
            {w.r.funct7, w.r.rs2} = 12'(next_rand(4096));
        end else if (kind < 13) begin
            w.u.opcode = OPC_LUI;
            w.u.imm20  = 20'(next_rand(1 << 20));
        end else if (kind < 15) begin
            // Forward jump of 2 to 6 words
            off        = 21'((next_rand(5) + 2) * 4);
            w.u.opcode = OPC_JAL;
            w.u.imm20  = {off[20], off[10:1], off[11], off[19:12]};
        end else begin
            w.r.opcode = 7'b0000011;  // load, not implemented
        end
        return w;
    endfunction

    initial begin : build_program
        for (int i = 0; i < NUM_WORDS; i++)
            mem[i] = random_instr();
    end

    ////////////////////////////////////////////////////////////
    // Instruction memory, aliases every 256 bytes
    ////////////////////////////////////////////////////////////

    always @(posedge I_sys_clk) begin
        if (I_rst) begin
            inst_ready <= 1'b0;
            inst_valid <= 1'b0;
            mem_busy = 1'b0;
        end else begin
            inst_valid <= 1'b0;
            // Response went out last cycle
            if (inst_valid)
                mem_busy = 1'b0;
            if (pc_valid && inst_ready) begin
                mem_busy = 1'b1;
                req_addr = pc;
                wait_cnt = next_rand(4);
            end
            if (mem_busy) begin
                if (wait_cnt == 0) begin
                    inst_valid <= 1'b1;
                    inst       <= mem[req_addr[7:2]];
                end else
                    wait_cnt--;
            end
            // Refuse about one request in four
            inst_ready <= (next_rand(4) != 0);
        end
    end

    ////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge I_sys_clk);
        $display("Timeout after %0d cycles, only %0d of %0d commits seen",
                 WATCHDOG_CYCLES, commit_count, NUM_COMMITS);
        $display("SIMULATION FAILED");
        $finish;
    end

    // Counters are read half a cycle after the compare edge
    initial begin : run_control
        int assert_fails;
        wait (I_rst === 1'b0);
        while (commit_count < NUM_COMMITS)
            @(negedge I_sys_clk);
        repeat (2) @(negedge I_sys_clk);
        assert_fails = u_dut.u_chk.fail_count;
        $display("Run finished: %0d commits, %0d compare errors, %0d assertion failures",
                 commit_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* files.f */
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/core_top.sv
test/tb_clock_gen.sv
test/core_chk.sv
test/tb_commit_monitor.sv
test/tb_core.sv
